// File: tests/exec_patterns.txt
// 16 data memory words first, then one operation per line, all hex:
// alu_op op_a op_b br_cond load_kind store_kind store_word imm result taken we wdata
12345678 80f07f01 deadbeef 00ffff00 cafebabe 00000001 ffffffff 7fff8000
a5a55a5a 01020304 f0f00f0f 13579bdf 2468ace0 80000000 00007f80 55aa33cc
// ALU operations
0 7fffffff 00000001 0 0 0 00000000 0000 80000000 0 0 00000000
1 00000003 00000005 0 0 0 00000000 0000 fffffffe 0 0 00000000
2 00000003 000007c0 0 0 0 00000000 0000 80000000 0 0 00000000
3 80000000 00000100 0 0 0 00000000 0000 08000000 0 0 00000000
4 80000000 00000100 0 0 0 00000000 0000 f8000000 0 0 00000000
5 00000024 0000000f 0 0 0 00000000 0000 000000f0 0 0 00000000
6 00000008 f0000000 0 0 0 00000000 0000 00f00000 0 0 00000000
7 00000008 f0000000 0 0 0 00000000 0000 fff00000 0 0 00000000
8 ff00ff00 0ff00ff0 0 0 0 00000000 0000 0f000f00 0 0 00000000
9 ff00ff00 0ff00ff0 0 0 0 00000000 0000 fff0fff0 0 0 00000000
a ff00ff00 0ff00ff0 0 0 0 00000000 0000 f0f0f0f0 0 0 00000000
b ff00ff00 0ff00ff0 0 0 0 00000000 0000 000f000f 0 0 00000000
c ffffffff 00000001 0 0 0 00000000 0000 00000001 0 0 00000000
d ffffffff 00000001 0 0 0 00000000 0000 00000000 0 0 00000000
d 00000001 ffffffff 0 0 0 00000000 0000 00000001 0 0 00000000
// branch conditions under sub, then a compare under add
1 80000000 00000000 1 0 0 00000000 0000 80000000 1 0 00000000
1 00000000 00000000 2 0 0 00000000 0000 00000000 1 0 00000000
1 00001234 00001234 3 0 0 00000000 0000 00000000 1 0 00000000
1 00001234 00001234 4 0 0 00000000 0000 00000000 0 0 00000000
1 00000000 00000000 5 0 0 00000000 0000 00000000 1 0 00000000
1 ffffffff 00000000 6 0 0 00000000 0000 ffffffff 0 0 00000000
1 00000001 00000000 6 0 0 00000000 0000 00000001 1 0 00000000
0 00000005 00000005 3 0 0 00000000 0000 0000000a 0 0 00000000
// stores at each legal offset
0 00000010 00000000 0 0 1 aabbccdd 0000 00000010 0 1 000000dd
0 00000011 00000000 0 0 1 aabbccdd 0000 00000011 0 2 0000dd00
0 00000012 00000000 0 0 1 aabbccdd 0000 00000012 0 4 00dd0000
0 00000010 00000003 0 0 1 aabbccdd 0000 00000013 0 8 dd000000
0 00000020 00000000 0 0 2 aabbccdd 0000 00000020 0 3 0000ccdd
0 00000020 00000002 0 0 2 aabbccdd 0000 00000022 0 c ccdd0000
0 00000030 00000004 0 0 3 aabbccdd 0000 00000034 0 f aabbccdd
// loads and lui
0 00000004 00000002 0 2 0 00000000 0000 fffffff0 0 0 00000000
0 00000004 00000002 0 5 0 00000000 0000 000000f0 0 0 00000000
0 00000004 00000002 0 3 0 00000000 0000 ffff80f0 0 0 00000000
0 00000004 00000000 0 6 0 00000000 0000 00007f01 0 0 00000000
0 00000008 00000000 0 4 0 00000000 0000 deadbeef 0 0 00000000
0 00000000 00000003 0 2 0 00000000 0000 00000012 0 0 00000000
0 00000000 00000000 0 1 0 00000000 beef beef0000 0 0 00000000
0 00000040 0000003c 0 4 0 00000000 0000 55aa33cc 0 0 00000000

// File: all.f
+incdir+common
common/exec_pkg.sv
hdl/alu_unit.sv
mem_stage/store_align.sv
mem_stage/load_align.sv
hdl/exec_pipe.sv
tests/exec_check.sv
tests/exec_tb.sv

// File: run.sh
#!/bin/sh
# builds the execute pipe testbench with Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module exec_tb -f all.f -o exec_sim || { echo "build failed"; exit 1; }
./obj_dir/exec_sim > sim.log 2>&1 || { echo "simulation exited abnormally"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "PASS"

// File: tests/exec_tb.sv
// testbench top for the execute pipe, drives operations read from the pattern file
`timescale 1ns/1ps

module exec_tb;

   localparam int MEM_WORDS    = 16;
   localparam int REC_FIELDS   = 12;
   localparam int MAX_RECS     = 48;
   localparam int PAT_WORDS    = MEM_WORDS + REC_FIELDS * MAX_RECS;
   localparam int RESET_CYCLES = 16;
   // leading ops that always go back to back
   localparam int RUN_IN       = 8;
   localparam logic [31:0] END_MARK = 32'hffff_ffff;

   logic                  clk = 1'b0;
   logic                  rst_b;
   logic                  issue;
   exec_pkg::alu_op_t     alu_op;
   exec_pkg::word_t       op_a;
   exec_pkg::word_t       op_b;
   exec_pkg::br_cond_t    br_cond;
   exec_pkg::load_kind_t  load_kind;
   exec_pkg::store_kind_t store_kind;
   exec_pkg::word_t       store_word;
   exec_pkg::half_t       imm;
   exec_pkg::word_t       mem_rdata;
   exec_pkg::word_addr_t  mem_addr;
   exec_pkg::word_t       mem_wdata;
   exec_pkg::byte_en_t    mem_we;
   logic                  done;
   exec_pkg::word_t       result;
   logic                  taken;

   // expected values travel with the issue strobe
   exec_pkg::word_t       exp_result;
   logic                  exp_taken;
   exec_pkg::byte_en_t    exp_we;
   exec_pkg::word_t       exp_wdata;
   int                    mismatches;
   int                    protocol_errs;
   int                    finished;

   // raw pattern words, unread entries keep the end marker
   logic [31:0]           pattern_words [0:PAT_WORDS-1];
   exec_pkg::word_t       mem_img [0:MEM_WORDS-1];
   int                    num_recs = 0;
   int                    cycle_count = 0;
   int                    cycle_limit;
   int                    gap;
   integer                seed = 32'h95ce_095b;

   always #10 clk = ~clk;

   exec_pipe exec_pipe_inst (
      .clk        (clk),
      .rst_b      (rst_b),
      .issue      (issue),
      .alu_op     (alu_op),
      .op_a       (op_a),
      .op_b       (op_b),
      .br_cond    (br_cond),
      .load_kind  (load_kind),
      .store_kind (store_kind),
      .store_word (store_word),
      .imm        (imm),
      .mem_rdata  (mem_rdata),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_we     (mem_we),
      .done       (done),
      .result     (result),
      .taken      (taken)
   );

   exec_check check_inst (
      .clk           (clk),
      .rst_b         (rst_b),
      .issue         (issue),
      .exp_result    (exp_result),
      .exp_taken     (exp_taken),
      .exp_we        (exp_we),
      .exp_wdata     (exp_wdata),
      .mem_addr      (mem_addr),
      .mem_we        (mem_we),
      .mem_wdata     (mem_wdata),
      .done          (done),
      .result        (result),
      .taken         (taken),
      .mismatches    (mismatches),
      .protocol_errs (protocol_errs),
      .finished      (finished)
   );

   // read-only data memory, answers in the same cycle
   assign mem_rdata = mem_img[mem_addr[3:0]];

   // puts one record on the DUT inputs and raises issue
   task automatic drive_record(input int idx);
      int base;
      base       = MEM_WORDS + idx * REC_FIELDS;
      alu_op     = exec_pkg::alu_op_t'(pattern_words[base][3:0]);
      op_a       = pattern_words[base + 1];
      op_b       = pattern_words[base + 2];
      br_cond    = exec_pkg::br_cond_t'(pattern_words[base + 3][2:0]);
      load_kind  = exec_pkg::load_kind_t'(pattern_words[base + 4][2:0]);
      store_kind = exec_pkg::store_kind_t'(pattern_words[base + 5][1:0]);
      store_word = pattern_words[base + 6];
      imm        = pattern_words[base + 7][15:0];
      exp_result = pattern_words[base + 8];
      exp_taken  = pattern_words[base + 9][0];
      exp_we     = pattern_words[base + 10][3:0];
      exp_wdata  = pattern_words[base + 11];
      issue      = 1'b1;
   endtask

   // run limit, four cycles per op covers the widest gap
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("error: run stopped after %0d cycles, %0d of %0d operations finished",
                  cycle_count, finished, num_recs);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      rst_b      = 1'b0;
      issue      = 1'b0;
      alu_op     = exec_pkg::ALU_ADD;
      op_a       = '0;
      op_b       = '0;
      br_cond    = exec_pkg::BR_NONE;
      load_kind  = exec_pkg::LD_NONE;
      store_kind = exec_pkg::ST_NONE;
      store_word = '0;
      imm        = '0;
      exp_result = '0;
      exp_taken  = 1'b0;
      exp_we     = '0;
      exp_wdata  = '0;
      for (int i = 0; i < PAT_WORDS; i++) begin
         pattern_words[i] = END_MARK;
      end
      $readmemh("tests/exec_patterns.txt", pattern_words);
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_img[i] = pattern_words[i];
      end
      // records end at the first alu_op word still holding the marker
      while (num_recs < MAX_RECS &&
             pattern_words[MEM_WORDS + num_recs * REC_FIELDS] != END_MARK) begin
         num_recs++;
      end
      if (num_recs == 0) begin
         $display("error: pattern file holds no operations");
      end
      cycle_limit = num_recs * 4 + RESET_CYCLES + 50;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_b = 1'b1;

      for (int i = 0; i < num_recs; i++) begin
         @(negedge clk);
         drive_record(i);
         // three in eight later ops leave an idle gap of one to three cycles
         gap = (i < RUN_IN) ? 0 : ($random(seed) & 7);
         if (gap > 3) begin
            gap = 0;
         end
         repeat (gap) begin
            @(negedge clk);
            issue = 1'b0;
         end
      end
      @(negedge clk);
      issue = 1'b0;

      wait (finished == num_recs);
      // two more cycles to catch a stray done, counts are settled by the next rising edge
      repeat (2) @(negedge clk);
      @(posedge clk);
      $display("errors: %0d mismatches, %0d protocol errors, %0d of %0d operations checked",
               mismatches, protocol_errs, finished, num_recs);
      if (mismatches + protocol_errs == 0 && num_recs > 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: tests/exec_check.sv
// watches the execute pipe ports and compares them with the values issued alongside each op
`timescale 1ns/1ps

module exec_check (
   input  logic                 clk,
   input  logic                 rst_b,
   input  logic                 issue,
   input  exec_pkg::word_t      exp_result,
   input  logic                 exp_taken,
   input  exec_pkg::byte_en_t   exp_we,
   input  exec_pkg::word_t      exp_wdata,
   input  exec_pkg::word_addr_t mem_addr,
   input  exec_pkg::byte_en_t   mem_we,
   input  exec_pkg::word_t      mem_wdata,
   input  logic                 done,
   input  exec_pkg::word_t      result,
   input  logic                 taken,
   output int                   mismatches,
   output int                   protocol_errs,
   output int                   finished
);

   // one op in flight, tag is the clock edge that took the issue
   typedef struct packed {
      logic [31:0]        tag;
      exec_pkg::word_t    result;
      logic               taken;
      exec_pkg::byte_en_t we;
      exec_pkg::word_t    wdata;
   } exp_rec_t;

   exp_rec_t    exp_q[$];
   exp_rec_t    new_rec;
   exp_rec_t    head;
   exp_rec_t    tail;
   logic [31:0] edge_count = '0;
   logic        expect_done;
   int          mismatch_cnt = 0;
   int          protocol_cnt = 0;
   int          finished_cnt = 0;

   assign mismatches    = mismatch_cnt;
   assign protocol_errs = protocol_cnt;
   assign finished      = finished_cnt;

   task automatic report_mismatch(input string sig, input exec_pkg::word_t want,
                                  input exec_pkg::word_t got);
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: %s expected %h got %h", $time, sig, want, got);
   endtask

   // inputs are steady at the rising edge, the DUT samples them here too
   always @(posedge clk) begin
      edge_count = edge_count + 32'd1;
      if (rst_b && issue) begin
         new_rec.tag    = edge_count;
         new_rec.result = exp_result;
         new_rec.taken  = exp_taken;
         new_rec.we     = exp_we;
         new_rec.wdata  = exp_wdata;
         exp_q.push_back(new_rec);
      end
   end

   // outputs settle after the rising edge, compare mid cycle
   always @(negedge clk) begin
      // stage two holds the op from one edge back
      expect_done = (exp_q.size() > 0) && (exp_q[0].tag == edge_count - 32'd1);
      if (expect_done) begin
         head = exp_q.pop_front();
         finished_cnt = finished_cnt + 1;
         if (done !== 1'b1) begin
            protocol_cnt = protocol_cnt + 1;
            $display("error at %0t: done missing for the operation issued at edge %0d",
                     $time, head.tag);
         end else begin
            if (result !== head.result) begin
               report_mismatch("result", head.result, result);
            end
            if (taken !== head.taken) begin
               report_mismatch("taken", exec_pkg::word_t'(head.taken),
                               exec_pkg::word_t'(taken));
            end
         end
      end else begin
         if (done !== 1'b0) begin
            protocol_cnt = protocol_cnt + 1;
            $display("error at %0t: done is high with no operation expected", $time);
         end
         if (taken !== 1'b0) begin
            report_mismatch("taken", '0, exec_pkg::word_t'(taken));
         end
      end

      // stage one drives the memory port
      if (exp_q.size() > 0) begin
         tail = exp_q[exp_q.size() - 1];
      end
      if (exp_q.size() > 0 && tail.tag == edge_count) begin
         if (mem_we !== tail.we) begin
            report_mismatch("mem_we", exec_pkg::word_t'(tail.we), exec_pkg::word_t'(mem_we));
         end
         if (mem_wdata !== tail.wdata) begin
            report_mismatch("mem_wdata", tail.wdata, mem_wdata);
         end
         // a store's result is its byte address, memory sees the word part
         if (tail.we != '0 && mem_addr !== tail.result[31:2]) begin
            report_mismatch("mem_addr", exec_pkg::word_t'(tail.result[31:2]),
                            exec_pkg::word_t'(mem_addr));
         end
      end else if (mem_we !== '0) begin
         report_mismatch("mem_we", '0, exec_pkg::word_t'(mem_we));
      end
   end

endmodule

// File: hdl/exec_pipe.sv
// two-stage execute and memory back end, one decoded operation in per issue strobe
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_pipe (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic                   issue,
   input  exec_pkg::alu_op_t      alu_op,
   input  exec_pkg::word_t        op_a,
   input  exec_pkg::word_t        op_b,
   input  exec_pkg::br_cond_t     br_cond,
   input  exec_pkg::load_kind_t   load_kind,
   input  exec_pkg::store_kind_t  store_kind,
   input  exec_pkg::word_t        store_word,
   input  exec_pkg::half_t        imm,
   input  exec_pkg::word_t        mem_rdata,
   output exec_pkg::word_addr_t   mem_addr,
   output exec_pkg::word_t        mem_wdata,
   output exec_pkg::byte_en_t     mem_we,
   output logic                   done,
   output exec_pkg::word_t        result,
   output logic                   taken
);

   // ALU outputs, still unregistered
   exec_pkg::word_t       alu_out;
   logic                  branch_met;

   // stage one, holds the op while memory is addressed
   logic                  s1_valid;
   exec_pkg::word_t       s1_alu;
   logic                  s1_branch_met;
   exec_pkg::load_kind_t  s1_load_kind;
   exec_pkg::store_kind_t s1_store_kind;
   exec_pkg::word_t       s1_store_word;
   exec_pkg::half_t       s1_imm;

   // aligner outputs
   exec_pkg::byte_en_t    lane_en;
   exec_pkg::word_t       load_data;

   alu_unit alu_unit_inst (
      .alu_op     (alu_op),
      .op_a       (op_a),
      .op_b       (op_b),
      .br_cond    (br_cond),
      .alu_out    (alu_out),
      .branch_met (branch_met)
   );

   // control half of stage one
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         s1_valid      <= 1'b0;
         s1_branch_met <= 1'b0;
         s1_load_kind  <= exec_pkg::LD_NONE;
         s1_store_kind <= exec_pkg::ST_NONE;
      end else begin
         // valid drops on any cycle without an issue
         s1_valid <= issue;
         if (issue) begin
            s1_branch_met <= branch_met;
            s1_load_kind  <= load_kind;
            s1_store_kind <= store_kind;
         end
      end
   end

   // data half of stage one
   always_ff @(posedge clk) begin
      if (issue) begin
         s1_alu        <= alu_out;
         s1_store_word <= store_word;
         s1_imm        <= imm;
      end
   end

   // effective address is the ALU sum, word part goes to memory
   assign mem_addr = s1_alu[`EXEC_WORD_W-1:`EXEC_OFS_W];

   store_align store_align_inst (
      .store_word (s1_store_word),
      .store_kind (s1_store_kind),
      .byte_ofs   (s1_alu[`EXEC_OFS_W-1:0]),
      .wdata      (mem_wdata),
      .lane_en    (lane_en)
   );

   // an empty stage must never write, whatever kind is left over
   assign mem_we = s1_valid ? lane_en : '0;

   load_align load_align_inst (
      .mem_rdata  (mem_rdata),
      .load_kind  (s1_load_kind),
      .byte_ofs   (s1_alu[`EXEC_OFS_W-1:0]),
      .imm        (s1_imm),
      .load_data  (load_data)
   );

   // stage two, single-cycle result strobe
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         done  <= 1'b0;
         taken <= 1'b0;
      end else begin
         done  <= s1_valid;
         taken <= s1_valid && s1_branch_met;
      end
   end

   // loads and lui return memory-path data, everything else the ALU value
   always_ff @(posedge clk) begin
      if (s1_valid) begin
         result <= (s1_load_kind != exec_pkg::LD_NONE) ? load_data : s1_alu;
      end
   end

   // fixed latency, done exactly two edges after each issue and never otherwise
   assert property (@(posedge clk) disable iff (!rst_b) done == $past(issue, 2))
      else $error("exec_pipe: done does not follow issue by two cycles");

   // lane enables only for a store issued on the edge before
   assert property (@(posedge clk) disable iff (!rst_b)
      (mem_we != '0) |-> $past(issue && store_kind != exec_pkg::ST_NONE))
      else $error("exec_pipe: write enables %b with no store in flight", mem_we);

endmodule

// File: mem_stage/load_align.sv
// shifts loaded memory data down by the byte offset and extends it per load kind
`timescale 1ns/1ps
`include "exec_macros.svh"

module load_align (
   input  exec_pkg::word_t        mem_rdata,
   input  exec_pkg::load_kind_t   load_kind,
   input  logic [`EXEC_OFS_W-1:0] byte_ofs,
   input  exec_pkg::half_t        imm,
   output exec_pkg::word_t        load_data
);

   localparam int BYTE_W = `EXEC_WORD_W / `EXEC_LANES;
   localparam int HALF_W = `EXEC_WORD_W / 2;

   // addressed byte or half moved down to bit 0
   exec_pkg::word_t shifted;

   assign shifted = mem_rdata >> {byte_ofs, 3'b000};

   always_comb begin
      load_data = '0;
      case (load_kind)
         // lui ignores memory and puts the immediate on top
         exec_pkg::LD_LUI: load_data = {imm, {HALF_W{1'b0}}};
         exec_pkg::LD_LB:
            load_data = {{(`EXEC_WORD_W-BYTE_W){shifted[BYTE_W-1]}}, shifted[BYTE_W-1:0]};
         exec_pkg::LD_LH:
            load_data = {{(`EXEC_WORD_W-HALF_W){shifted[HALF_W-1]}}, shifted[HALF_W-1:0]};
         // full word, offset is zero for an aligned lw
         exec_pkg::LD_LW:  load_data = mem_rdata;
         exec_pkg::LD_LBU:
            load_data = {{(`EXEC_WORD_W-BYTE_W){1'b0}}, shifted[BYTE_W-1:0]};
         exec_pkg::LD_LHU:
            load_data = {{(`EXEC_WORD_W-HALF_W){1'b0}}, shifted[HALF_W-1:0]};
         default:          load_data = '0;
      endcase
   end

endmodule

// File: mem_stage/store_align.sv
// lines store data up with its byte lanes and builds the lane write enables
`timescale 1ns/1ps
`include "exec_macros.svh"

module store_align (
   input  exec_pkg::word_t          store_word,
   input  exec_pkg::store_kind_t    store_kind,
   input  logic [`EXEC_OFS_W-1:0]   byte_ofs,
   output exec_pkg::word_t          wdata,
   output exec_pkg::byte_en_t       lane_en
);

   localparam int BYTE_W = `EXEC_WORD_W / `EXEC_LANES;
   localparam int HALF_W = `EXEC_WORD_W / 2;

   // bit distance for the lane move, eight per byte of offset
   logic [`EXEC_OFS_W+2:0] bit_shift;
   // data bits that the lane enables allow, one byte per lane
   exec_pkg::word_t        lane_mask;

   assign bit_shift = {byte_ofs, 3'b000};
   assign lane_mask = {{BYTE_W{lane_en[3]}}, {BYTE_W{lane_en[2]}},
                       {BYTE_W{lane_en[1]}}, {BYTE_W{lane_en[0]}}};

   always_comb begin
      wdata   = '0;
      lane_en = '0;
      case (store_kind)
         exec_pkg::ST_SB: begin
            wdata   = exec_pkg::word_t'(store_word[BYTE_W-1:0]) << bit_shift;
            lane_en = exec_pkg::byte_en_t'(1) << byte_ofs;
         end
         // sh expects an even offset, the upper lane falls off otherwise
         exec_pkg::ST_SH: begin
            wdata   = exec_pkg::word_t'(store_word[HALF_W-1:0]) << bit_shift;
            lane_en = exec_pkg::byte_en_t'(3) << byte_ofs;
         end
         exec_pkg::ST_SW: begin
            wdata   = store_word;
            lane_en = '1;
         end
         default: begin
            wdata   = '0;
            lane_en = '0;
         end
      endcase
   end

   // a byte store touches one lane only, and no store puts data outside its lanes
   always_comb begin
      assert final ((store_kind != exec_pkg::ST_SB || $onehot(lane_en)) &&
                    ((wdata & ~lane_mask) == '0))
         else $error("store_align: lane enables %b for data %h", lane_en, wdata);
   end

endmodule

// File: hdl/alu_unit.sv
// combinational ALU for the execute stage, also resolves branch conditions during sub
`timescale 1ns/1ps
`include "exec_macros.svh"

module alu_unit (
   input  exec_pkg::alu_op_t  alu_op,
   input  exec_pkg::word_t    op_a,
   input  exec_pkg::word_t    op_b,
   input  exec_pkg::br_cond_t br_cond,
   output exec_pkg::word_t    alu_out,
   output logic               branch_met
);

   // shift amounts for the two shift flavours
   exec_pkg::shamt_t imm_shamt;
   exec_pkg::shamt_t var_shamt;
   // sign and zero tests of op_a for the compare-with-zero branches
   logic a_neg;
   logic a_zero;

   // immediate shifts take shamt out of the encoded immediate
   assign imm_shamt = op_b[`EXEC_SHAMT_HI:`EXEC_SHAMT_LO];
   // variable shifts use the low bits of rs
   assign var_shamt = op_a[$bits(exec_pkg::shamt_t)-1:0];

   assign a_neg  = op_a[`EXEC_WORD_W-1];
   assign a_zero = (op_a == '0);

   always_comb begin
      alu_out = '0;
      case (alu_op)
         exec_pkg::ALU_ADD:  alu_out = op_a + op_b;
         exec_pkg::ALU_SUB:  alu_out = op_a - op_b;
         // immediate shifts move op_a
         exec_pkg::ALU_SLL:  alu_out = op_a << imm_shamt;
         exec_pkg::ALU_SRL:  alu_out = op_a >> imm_shamt;
         exec_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> imm_shamt;
         // variable shifts move op_b (rt) by rs
         exec_pkg::ALU_SLLV: alu_out = op_b << var_shamt;
         exec_pkg::ALU_SRLV: alu_out = op_b >> var_shamt;
         exec_pkg::ALU_SRAV: alu_out = $signed(op_b) >>> var_shamt;
         exec_pkg::ALU_AND:  alu_out = op_a & op_b;
         exec_pkg::ALU_OR:   alu_out = op_a | op_b;
         exec_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
         exec_pkg::ALU_NOR:  alu_out = ~(op_a | op_b);
         // set-less-than gives 0 or 1 in bit 0
         exec_pkg::ALU_SLT:  alu_out = exec_pkg::word_t'($signed(op_a) < $signed(op_b));
         exec_pkg::ALU_SLTU: alu_out = exec_pkg::word_t'(op_a < op_b);
         default:            alu_out = '0;
      endcase
   end

   // branch decision, a branch always issues as a subtract
   always_comb begin
      branch_met = 1'b0;
      if (alu_op == exec_pkg::ALU_SUB) begin
         case (br_cond)
            exec_pkg::BR_BLTZ: branch_met = a_neg;
            exec_pkg::BR_BGEZ: branch_met = !a_neg;
            exec_pkg::BR_BEQ:  branch_met = (op_a == op_b);
            exec_pkg::BR_BNE:  branch_met = (op_a != op_b);
            exec_pkg::BR_BLEZ: branch_met = a_neg || a_zero;
            exec_pkg::BR_BGTZ: branch_met = !a_neg && !a_zero;
            default:           branch_met = 1'b0;
         endcase
      end
   end

   // taken only under sub, and a taken beq or bne must agree with the difference
   always_comb begin
      assert final (!branch_met || (alu_op == exec_pkg::ALU_SUB &&
                    (br_cond != exec_pkg::BR_BEQ || alu_out == '0) &&
                    (br_cond != exec_pkg::BR_BNE || alu_out != '0)))
         else $error("alu_unit: branch_met high with alu_op %0d br_cond %0d diff %h",
                     alu_op, br_cond, alu_out);
   end

endmodule

// File: common/exec_pkg.sv
// shared word, lane and operation-code types for the execute pipe and its testbench
package exec_pkg;

`include "exec_macros.svh"

   // data and address widths
   typedef logic [`EXEC_WORD_W-1:0] word_t;
   typedef logic [`EXEC_WORD_W/2-1:0] half_t;
   typedef logic [`EXEC_WORD_W-`EXEC_OFS_W-1:0] word_addr_t;
   typedef logic [`EXEC_LANES-1:0] byte_en_t;
   typedef logic [`EXEC_SHAMT_HI-`EXEC_SHAMT_LO:0] shamt_t;

   // ALU operations, codes fixed since pattern files carry them as hex
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SRL  = 4'd3,
      ALU_SRA  = 4'd4,
      ALU_SLLV = 4'd5,
      ALU_SRLV = 4'd6,
      ALU_SRAV = 4'd7,
      ALU_AND  = 4'd8,
      ALU_OR   = 4'd9,
      ALU_XOR  = 4'd10,
      ALU_NOR  = 4'd11,
      ALU_SLT  = 4'd12,
      ALU_SLTU = 4'd13
   } alu_op_t;

   // branch tests, only looked at while the ALU subtracts
   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_BLTZ = 3'd1,
      BR_BGEZ = 3'd2,
      BR_BEQ  = 3'd3,
      BR_BNE  = 3'd4,
      BR_BLEZ = 3'd5,
      BR_BGTZ = 3'd6
   } br_cond_t;

   // load result shaping
   typedef enum logic [2:0] {
      LD_NONE = 3'd0,
      LD_LUI  = 3'd1,
      LD_LB   = 3'd2,
      LD_LH   = 3'd3,
      LD_LW   = 3'd4,
      LD_LBU  = 3'd5,
      LD_LHU  = 3'd6
   } load_kind_t;

   // store sizes
   typedef enum logic [1:0] {
      ST_NONE = 2'd0,
      ST_SB   = 2'd1,
      ST_SH   = 2'd2,
      ST_SW   = 2'd3
   } store_kind_t;

endpackage

// File: common/exec_macros.svh
// width and field-position constants for the execute back end, included by package and RTL
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// one data word on the memory port and through the ALU
`define EXEC_WORD_W 32

// byte lanes per word, one write enable each
`define EXEC_LANES 4

// byte offset bits at the bottom of a byte address
`define EXEC_OFS_W 2

// shift amount field inside operand b for the immediate shifts
// (same place as the shamt field of an R-type instruction)
`define EXEC_SHAMT_LO 6
`define EXEC_SHAMT_HI 10

`endif
